// ==== axi_wr_pkg.sv ====
// Write-port constants; single fixed burst shape, no IDs, WSTRB all ones assumed by the slave
package axi_wr_pkg;

	// ------------------------------------------------------------------------
	// Data bus and beat shape
	// ------------------------------------------------------------------------
	localparam int DATA_W     = 64;               // AXI write data width
	localparam int LANE_W     = 16;               // Pattern lane width
	localparam int LANES      = DATA_W / LANE_W;  // Lanes per beat
	localparam int BEATS      = 4;                // Beats per burst
	localparam int BEAT_BYTES = DATA_W / 8;       // Bytes per beat
	localparam int BEAT_W     = $clog2(BEATS);    // Beat counter width

	// ------------------------------------------------------------------------
	// AXI4 field encodings
	// ------------------------------------------------------------------------
	localparam logic [7:0] AXI_LEN   = 8'(BEATS - 1);               // AWLEN
	localparam logic [2:0] AXI_SIZE  = 3'($clog2(BEAT_BYTES));      // AWSIZE for 8 bytes
	localparam logic [1:0] AXI_INCR  = 2'b01;                       // AWBURST INCR
	localparam logic [1:0] RESP_OKAY = 2'b00;                       // BRESP OKAY

	// Burst sequencer state codes
	localparam logic [1:0] ST_IDLE = 2'd0;    // Waiting for enable
	localparam logic [1:0] ST_ADDR = 2'd1;    // AWVALID up
	localparam logic [1:0] ST_DATA = 2'd2;    // WVALID up
	localparam logic [1:0] ST_RESP = 2'd3;    // BREADY up

	// ------------------------------------------------------------------------
	// Burst time averaging
	// ------------------------------------------------------------------------
	localparam int AVG_W     = 8;                     // Cycle count width, saturating
	localparam int AVG_DEPTH = 8;                     // Ring entries
	localparam int AVG_PTR_W = $clog2(AVG_DEPTH);     // Ring pointer width
	localparam int AVG_SUM_W = AVG_W + AVG_PTR_W;     // Sum of all entries

endpackage

// ==== ddr_map_pkg.sv ====
// DDR address map; column is always zero so every burst is aligned to 32 bytes
package ddr_map_pkg;

	// ------------------------------------------------------------------------
	// Address field widths
	// ------------------------------------------------------------------------
	localparam int ADDR_W = 32;     // AXI byte address
	localparam int COL_W  = 5;      // Byte offset inside one burst
	localparam int BANK_W = 3;      // Bank select
	localparam int PAGE_W = 10;     // Page (row) select

	// Unused upper bits
	localparam int PAD_W = ADDR_W - PAGE_W - BANK_W - COL_W;

	// ------------------------------------------------------------------------
	// Test window
	// ------------------------------------------------------------------------
	localparam logic [BANK_W-1:0] START_BANK = BANK_W'(0);
	localparam logic [BANK_W-1:0] STOP_BANK  = BANK_W'(7);    // Last bank before page step
	localparam logic [PAGE_W-1:0] START_PAGE = PAGE_W'(0);
	localparam logic [PAGE_W-1:0] STOP_PAGE  = PAGE_W'(3);    // Wrap point of the page window

	// ------------------------------------------------------------------------
	// One address word, two views
	// ------------------------------------------------------------------------
	typedef union packed {
		logic [ADDR_W-1:0] flat;                // Byte address as seen on AWADDR
		struct packed {
			logic [PAD_W-1:0]  pad;             // Always zero
			logic [PAGE_W-1:0] page;
			logic [BANK_W-1:0] bank;
			logic [COL_W-1:0]  col;             // Burst aligned
		} fld;
	} ddr_addr_u;

endpackage

// ==== wr_addr_gen.sv ====
// Bank-first address stepping; steps only on i_next, page window wraps with no end flag
`timescale 1ns/1ps

module wr_addr_gen (
	input  logic                   iCLK,
	input  logic                   iRST,
	input  logic                   i_next,     // One burst completed
	output ddr_map_pkg::ddr_addr_u o_addr      // Address of the current burst
);

	import ddr_map_pkg::*;

	logic [BANK_W-1:0] bank_q;     // Current bank
	logic [PAGE_W-1:0] page_q;     // Current page
	logic              bank_wrap;  // Last bank reached

	assign bank_wrap = (bank_q == STOP_BANK);

	// ------------------------------------------------------------------------
	// Bank and page registers
	// ------------------------------------------------------------------------
	always_ff @(posedge iCLK)
	begin
		if (iRST)
		begin
			bank_q <= START_BANK;
			page_q <= START_PAGE;
		end
		else if (i_next)
		begin
			if (bank_wrap)
			begin
				bank_q <= START_BANK;                       // Back to first bank
				if (page_q == STOP_PAGE)
					page_q <= START_PAGE;                   // Page window wrap
				else
					page_q <= page_q + 1'b1;
			end
			else
			begin
				bank_q <= bank_q + 1'b1;                    // Next bank same page
			end
		end
	end

	// Field view of the address
	always_comb
	begin
		o_addr          = '0;
		o_addr.fld.pad  = '0;
		o_addr.fld.page = page_q;
		o_addr.fld.bank = bank_q;
		o_addr.fld.col  = '0;      // Burst starts at column zero
	end

endmodule

// ==== wr_pattern_gen.sv ====
// Running-count write data; counters never restart between bursts, only on reset
`timescale 1ns/1ps

module wr_pattern_gen (
	input  logic                          iCLK,
	input  logic                          iRST,
	input  logic                          i_next,    // W handshake seen
	output logic [axi_wr_pkg::DATA_W-1:0] o_wdata    // Beat on the bus
);

	import axi_wr_pkg::*;

	// Lane x sits at bits x*16 upward
	logic [LANES-1:0][LANE_W-1:0] lane_q;

	// ------------------------------------------------------------------------
	// Lane counters
	// ------------------------------------------------------------------------
	always_ff @(posedge iCLK)
	begin
		if (iRST)
		begin
			for (int i = 0; i < LANES; i++)
			begin
				lane_q[i] <= LANE_W'(i);                    // Lane x starts at x
			end
		end
		else if (i_next)
		begin
			for (int i = 0; i < LANES; i++)
			begin
				lane_q[i] <= lane_q[i] + LANE_W'(LANES);    // Wraps at 16 bits
			end
		end
	end

	assign o_wdata = lane_q;   // Held until the next accepted beat

endmodule

// ==== wr_burst_ctrl.sv ====
// One burst outstanding; i_enable is sampled only in idle and at the B handshake
`timescale 1ns/1ps

module wr_burst_ctrl (
	input  logic       iCLK,
	input  logic       iRST,
	input  logic       i_enable,       // Keep issuing bursts
	// AW channel
	input  logic       i_awready,
	output logic       o_awvalid,
	// W channel
	input  logic       i_wready,
	output logic       o_wvalid,
	output logic       o_wlast,
	// B channel
	input  logic       i_bvalid,
	input  logic [1:0] i_bresp,
	output logic       o_bready,
	// Internal strobes
	output logic       o_beat_acc,     // W handshake
	output logic       o_resp_acc,     // B handshake
	output logic       o_burst_start,  // First cycle of AWVALID
	// Status
	output logic       o_wdone,        // Burst finished
	output logic       o_resp_err      // Sticky non-OKAY response
);

	import axi_wr_pkg::*;

	logic [1:0]        state_q;        // Sequencer state
	logic [BEAT_W-1:0] beat_q;         // Beat index inside the burst
	logic              aw_hs;
	logic              w_hs;
	logic              b_hs;
	logic              start_burst;    // Next cycle enters the address phase
	logic              burst_start_q;
	logic              wdone_q;
	logic              resp_err_q;

	// ------------------------------------------------------------------------
	// Channel decode
	// ------------------------------------------------------------------------
	assign o_awvalid = (state_q == ST_ADDR);
	assign o_wvalid  = (state_q == ST_DATA);
	assign o_bready  = (state_q == ST_RESP);
	assign o_wlast   = (beat_q == BEAT_W'(BEATS - 1));    // Last beat only

	assign aw_hs = o_awvalid & i_awready;
	assign w_hs  = o_wvalid & i_wready;
	assign b_hs  = o_bready & i_bvalid;

	// From idle or straight after the response
	assign start_burst = i_enable & ((state_q == ST_IDLE) | b_hs);

	// ------------------------------------------------------------------------
	// Sequencer
	// ------------------------------------------------------------------------
	always_ff @(posedge iCLK)
	begin
		if (iRST)
			state_q <= ST_IDLE;
		else
		begin
			case (state_q)
				ST_IDLE: if (i_enable)         state_q <= ST_ADDR;
				ST_ADDR: if (aw_hs)            state_q <= ST_DATA;
				ST_DATA: if (w_hs && o_wlast)  state_q <= ST_RESP;
				ST_RESP: if (b_hs)             state_q <= i_enable ? ST_ADDR : ST_IDLE;
				default:                       state_q <= ST_IDLE;
			endcase
		end
	end

	// Beat counter
	always_ff @(posedge iCLK)
	begin
		if (iRST)
			beat_q <= '0;
		else if (w_hs)
			beat_q <= o_wlast ? '0 : beat_q + 1'b1;    // Ready for the next burst
	end

	// Registered strobes and status
	always_ff @(posedge iCLK)
	begin
		if (iRST)
		begin
			burst_start_q <= 1'b0;
			wdone_q       <= 1'b0;
			resp_err_q    <= 1'b0;
		end
		else
		begin
			burst_start_q <= start_burst;     // Lines up with AWVALID rise
			wdone_q       <= b_hs;            // Single cycle
			if (b_hs && (i_bresp != RESP_OKAY))
				resp_err_q <= 1'b1;           // Only reset clears it
		end
	end

	assign o_beat_acc    = w_hs;
	assign o_resp_acc    = b_hs;
	assign o_burst_start = burst_start_q;
	assign o_wdone       = wdone_q;
	assign o_resp_err    = resp_err_q;

endmodule

// ==== wr_speed_avg.sv ====
// Burst time average over eight bursts; counts saturate at 255 and the first seven include zeros
`timescale 1ns/1ps

module wr_speed_avg (
	input  logic                         iCLK,
	input  logic                         iRST,
	input  logic                         i_start,       // AWVALID rise
	input  logic                         i_done,        // B handshake
	output logic [axi_wr_pkg::AVG_W-1:0] o_avg_cycles   // Mean burst time
);

	import axi_wr_pkg::*;

	logic                 busy_q;                 // Burst in flight
	logic [AVG_W-1:0]     cnt_q;                  // Cycles so far, done cycle excluded
	logic [AVG_W-1:0]     cnt_inc;                // Saturating increment
	logic [AVG_W-1:0]     ring_q [AVG_DEPTH];     // Last eight burst times
	logic [AVG_PTR_W-1:0] wr_ptr_q;
	logic [AVG_SUM_W-1:0] sum_all;
	logic [AVG_SUM_W-1:0] sum_q;
	logic [AVG_W-1:0]     avg_q;

	assign cnt_inc = (&cnt_q) ? cnt_q : cnt_q + 1'b1;    // Stick at 255

	// ------------------------------------------------------------------------
	// Burst time counter
	// ------------------------------------------------------------------------
	always_ff @(posedge iCLK)
	begin
		if (iRST)
		begin
			busy_q <= 1'b0;
			cnt_q  <= '0;
		end
		else if (i_start)
		begin
			busy_q <= 1'b1;
			cnt_q  <= AVG_W'(1);       // Start cycle counts
		end
		else if (i_done)
			busy_q <= 1'b0;
		else if (busy_q)
			cnt_q <= cnt_inc;
	end

	// Ring write, done cycle included
	always_ff @(posedge iCLK)
	begin
		if (iRST)
		begin
			wr_ptr_q <= '0;
			for (int i = 0; i < AVG_DEPTH; i++)
				ring_q[i] <= '0;
		end
		else if (i_done)
		begin
			ring_q[wr_ptr_q] <= cnt_inc;
			wr_ptr_q         <= wr_ptr_q + 1'b1;    // Wraps at eight
		end
	end

	// ------------------------------------------------------------------------
	// Sum then divide, one register each
	// ------------------------------------------------------------------------
	always_comb
	begin
		sum_all = '0;
		for (int i = 0; i < AVG_DEPTH; i++)
			sum_all = sum_all + AVG_SUM_W'(ring_q[i]);
	end

	always_ff @(posedge iCLK)
	begin
		if (iRST)
		begin
			sum_q <= '0;
			avg_q <= '0;
		end
		else
		begin
			sum_q <= sum_all;
			avg_q <= AVG_W'(sum_q >> AVG_PTR_W);   // Truncating divide by eight
		end
	end

	assign o_avg_cycles = avg_q;

endmodule

// ==== ddr_wr_traffic.sv ====
// AXI4 write traffic top; AWLEN, AWSIZE, AWBURST and WSTRB are fixed and not driven as ports
`timescale 1ns/1ps

module ddr_wr_traffic (
	input  logic                            iCLK,
	input  logic                            iRST,
	input  logic                            i_enable,
	// AW channel
	output logic [ddr_map_pkg::ADDR_W-1:0]  o_awaddr,
	output logic                            o_awvalid,
	input  logic                            i_awready,
	// W channel
	output logic [axi_wr_pkg::DATA_W-1:0]   o_wdata,
	output logic                            o_wlast,
	output logic                            o_wvalid,
	input  logic                            i_wready,
	// B channel
	input  logic [1:0]                      i_bresp,
	input  logic                            i_bvalid,
	output logic                            o_bready,
	// Status
	output logic                            o_wdone,
	output logic                            o_resp_err,
	output logic [axi_wr_pkg::AVG_W-1:0]    o_avg_cycles
);

	import ddr_map_pkg::*;

	logic      beat_acc;      // W handshake
	logic      resp_acc;      // B handshake
	logic      burst_start;   // AWVALID rise
	ddr_addr_u awaddr_u;

	// ------------------------------------------------------------------------
	// Sequencer and its helpers
	// ------------------------------------------------------------------------
	wr_burst_ctrl u_ctrl (
		.iCLK(iCLK),               .iRST(iRST),
		.i_enable(i_enable),
		.i_awready(i_awready),     .o_awvalid(o_awvalid),
		.i_wready(i_wready),       .o_wvalid(o_wvalid),       .o_wlast(o_wlast),
		.i_bvalid(i_bvalid),       .i_bresp(i_bresp),         .o_bready(o_bready),
		.o_beat_acc(beat_acc),     .o_resp_acc(resp_acc),     .o_burst_start(burst_start),
		.o_wdone(o_wdone),         .o_resp_err(o_resp_err)
	);

	wr_addr_gen u_addr (.iCLK(iCLK), .iRST(iRST), .i_next(resp_acc), .o_addr(awaddr_u));

	wr_pattern_gen u_data (.iCLK(iCLK), .iRST(iRST), .i_next(beat_acc), .o_wdata(o_wdata));

	wr_speed_avg u_speed (
		.iCLK(iCLK),               .iRST(iRST),
		.i_start(burst_start),     .i_done(resp_acc),
		.o_avg_cycles(o_avg_cycles)
	);

	assign o_awaddr = awaddr_u.flat;   // Flat byte view on the bus

endmodule

// ==== ddr_wr_traffic_asserts.sv ====
// Handshake rules on the top-level write port; inactive while iRST is high, bound by the testbench
`timescale 1ns/1ps

module ddr_wr_traffic_asserts (
	input  logic                           iCLK,
	input  logic                           iRST,
	input  logic                           i_awvalid,
	input  logic                           i_awready,
	input  logic [ddr_map_pkg::ADDR_W-1:0] i_awaddr,
	input  logic                           i_wvalid,
	input  logic                           i_wready,
	input  logic [axi_wr_pkg::DATA_W-1:0]  i_wdata,
	input  logic                           i_wlast,
	input  logic                           i_wdone
);

	// AW payload frozen while stalled
	aw_hold: assert property (@(posedge iCLK) disable iff (iRST)
		(i_awvalid && !i_awready) |=> (i_awvalid && $stable(i_awaddr)))
	else
	begin
		$error("AWVALID dropped or AWADDR moved before AWREADY");
		tb_ddr_wr_traffic.err_cnt++;
	end

	// W payload frozen while stalled
	w_hold: assert property (@(posedge iCLK) disable iff (iRST)
		(i_wvalid && !i_wready) |=> (i_wvalid && $stable(i_wdata) && $stable(i_wlast)))
	else
	begin
		$error("WVALID dropped or WDATA/WLAST moved before WREADY");
		tb_ddr_wr_traffic.err_cnt++;
	end

	wlast_valid: assert property (@(posedge iCLK) disable iff (iRST) i_wlast |-> i_wvalid)
	else
	begin
		$error("WLAST high without WVALID");
		tb_ddr_wr_traffic.err_cnt++;
	end

	wdone_pulse: assert property (@(posedge iCLK) disable iff (iRST) i_wdone |=> !i_wdone)
	else
	begin
		$error("o_wdone held longer than one cycle");
		tb_ddr_wr_traffic.err_cnt++;
	end

endmodule

// ==== tb_ddr_wr_traffic.sv ====
// Random-ready AXI slave with one response in flight; burst times assumed below 256 cycles
`timescale 1ns/1ps

module tb_ddr_wr_traffic;

	import axi_wr_pkg::*;
	import ddr_map_pkg::*;

	localparam int CLK_NS      = 20;
	localparam int WATCHDOG_NS = 40 * 200 * CLK_NS;    // 40 bursts of up to 200 cycles

	logic              iCLK      = 1'b0;
	logic              iRST      = 1'b1;
	logic              i_enable  = 1'b0;
	logic              i_awready = 1'b0;
	logic              i_wready  = 1'b0;
	logic              i_bvalid  = 1'b0;
	logic [1:0]        i_bresp   = 2'b00;
	logic [ADDR_W-1:0] o_awaddr;
	logic [DATA_W-1:0] o_wdata;
	logic [AVG_W-1:0]  o_avg_cycles;
	logic              o_awvalid, o_wvalid, o_wlast, o_bready, o_wdone, o_resp_err;

	integer     seed     = 32'h3c2a;      // $random state
	logic [1:0] resp_sel = RESP_OKAY;     // Response the current test wants
	int         err_cnt, chk_cnt, data_err, addr_err, snap, mark, base;
	int         aw_idx, beat_idx, aw_rise, b_cnt, done_cnt, cyc, b_pend;
	logic       aw_prev, in_burst;
	int         burst_times[$];           // Measured at the ports

	ddr_wr_traffic uut (.*);

	bind ddr_wr_traffic ddr_wr_traffic_asserts u_asserts (
		.iCLK(iCLK),            .iRST(iRST),
		.i_awvalid(o_awvalid),  .i_awready(i_awready),  .i_awaddr(o_awaddr),
		.i_wvalid(o_wvalid),    .i_wready(i_wready),    .i_wdata(o_wdata),
		.i_wlast(o_wlast),      .i_wdone(o_wdone)
	);

	always #(CLK_NS / 2) iCLK = ~iCLK;

	// ------------------------------------------------------------------------
	// Expected values
	// ------------------------------------------------------------------------
	// Bank first, then page, inside the window
	function automatic logic [ADDR_W-1:0] exp_addr(input int k);
		int nb;
		int bank;
		int page;
		nb   = int'(STOP_BANK) - int'(START_BANK) + 1;
		bank = int'(START_BANK) + k % nb;
		page = int'(START_PAGE) + (k / nb) % (int'(STOP_PAGE) - int'(START_PAGE) + 1);
		return ADDR_W'((page << (COL_W + BANK_W)) | (bank << COL_W));
	endfunction

	function automatic logic [DATA_W-1:0] exp_data(input int g);
		logic [DATA_W-1:0] d;
		for (int x = 0; x < LANES; x++)
			d[x*LANE_W +: LANE_W] = LANE_W'(LANES * g + x);    // Lane x of beat g
		return d;
	endfunction

	// Mean of the last eight, missing entries count as zero
	function automatic logic [AVG_W-1:0] exp_avg();
		int sum;
		int t;
		sum = 0;
		for (int i = 0; i < 8 && i < burst_times.size(); i++)
		begin
			t   = burst_times[burst_times.size() - 1 - i];
			sum = sum + ((t > 255) ? 255 : t);              // Counter saturates
		end
		return AVG_W'(sum / 8);
	endfunction

	// ------------------------------------------------------------------------
	// Compare tasks
	// ------------------------------------------------------------------------
	task automatic check_addr(input string name, input logic [ADDR_W-1:0] act, exp);
		chk_cnt++;
		if (act !== exp)
		begin
			err_cnt++;
			$display("FAIL at %0t ns: %s expected %h got %h", $time, name, exp, act);
		end
	endtask

	task automatic check_data(input string name, input logic [DATA_W-1:0] act, exp);
		chk_cnt++;
		if (act !== exp)
		begin
			err_cnt++;
			$display("FAIL at %0t ns: %s expected %h got %h", $time, name, exp, act);
		end
	endtask

	task automatic check_bit(input string name, input logic act, exp);
		chk_cnt++;
		if (act !== exp)
		begin
			err_cnt++;
			$display("FAIL at %0t ns: %s expected %b got %b", $time, name, exp, act);
		end
	endtask

	task automatic check_avg(input string name, input logic [AVG_W-1:0] act, exp);
		chk_cnt++;
		if (act !== exp)
		begin
			err_cnt++;
			$display("FAIL at %0t ns: %s expected %0d got %0d", $time, name, exp, act);
		end
	endtask

	// Nothing in flight, error flag as given
	task automatic check_idle(input logic exp_err);
		check_bit("o_awvalid", o_awvalid, 1'b0);
		check_bit("o_wvalid", o_wvalid, 1'b0);
		check_bit("o_bready", o_bready, 1'b0);
		check_bit("o_wdone", o_wdone, 1'b0);
		check_bit("o_resp_err", o_resp_err, exp_err);
	endtask

	task automatic wait_idle();
		@(negedge iCLK);
		while (o_awvalid || o_wvalid || o_bready)
			@(negedge iCLK);
	endtask

	// ------------------------------------------------------------------------
	// AXI slave, random ready and response delay
	// ------------------------------------------------------------------------
	always @(posedge iCLK)
	begin
		if (iRST)
		begin
			i_awready <= 1'b0;
			i_wready  <= 1'b0;
			i_bvalid  <= 1'b0;
			b_pend = 0;
		end
		else
		begin
			i_awready <= ($random(seed) & 3) != 0;    // Ready three times in four
			i_wready  <= ($random(seed) & 3) != 0;
			if (o_wvalid && i_wready && o_wlast)
				b_pend++;                             // Burst owes a response
			if (i_bvalid && o_bready)
			begin
				i_bvalid <= 1'b0;
				b_pend--;
			end
			else if (!i_bvalid && b_pend > 0 && ($random(seed) & 1))
			begin
				i_bvalid <= 1'b1;                     // Held until BREADY
				i_bresp  <= resp_sel;
			end
		end
	end

	// Port monitor, sampled mid-cycle
	always @(negedge iCLK)
	begin
		if (iRST)
		begin
			aw_idx   = 0;
			beat_idx = 0;
			aw_prev  = 1'b0;
			in_burst = 1'b0;
		end
		else
		begin
			if (o_awvalid && !aw_prev)
			begin
				in_burst = 1'b1;      // AWVALID rise opens the burst time
				cyc      = 1;
				aw_rise++;
			end
			else if (in_burst)
				cyc++;
			aw_prev = o_awvalid;
			if (o_awvalid && i_awready)
			begin
				snap = err_cnt;
				check_addr("o_awaddr", o_awaddr, exp_addr(aw_idx));
				addr_err += err_cnt - snap;
				aw_idx++;
			end
			if (o_wvalid && i_wready)
			begin
				snap = err_cnt;
				check_data("o_wdata", o_wdata, exp_data(beat_idx));
				check_bit("o_wlast", o_wlast, (beat_idx % BEATS) == BEATS - 1);
				data_err += err_cnt - snap;
				beat_idx++;
			end
			if (o_bready && i_bvalid)
			begin
				burst_times.push_back(cyc);    // B cycle included
				in_burst = 1'b0;
				b_cnt++;
			end
			if (o_wdone)
				done_cnt++;
		end
	end

	// ------------------------------------------------------------------------
	// Test sequence
	// ------------------------------------------------------------------------
	initial
	begin
		repeat (2) @(negedge iCLK);
		check_idle(1'b0);                    // Still in reset
		check_avg("o_avg_cycles", o_avg_cycles, '0);
		repeat (2) @(posedge iCLK);
		iRST <= 1'b0;                        // Fourth rising edge
		repeat (3) @(negedge iCLK);
		check_idle(1'b0);
		check_avg("o_avg_cycles", o_avg_cycles, '0);
		$display("Test 1 reset state: %0d errors", err_cnt);

		// Data, WLAST and address over 40 bursts
		@(posedge iCLK);
		i_enable <= 1'b1;
		wait (b_cnt >= 40);
		if (beat_idx != BEATS * b_cnt || aw_idx != b_cnt)
		begin
			err_cnt++;
			data_err++;
			$display("ERROR at %0t ns: %0d AW and %0d W transfers for %0d responses",
				$time, aw_idx, beat_idx, b_cnt);
		end
		$display("Test 2 data and WLAST: %0d beats, %0d errors", beat_idx, data_err);
		$display("Test 3 address sequence: %0d bursts, %0d errors", aw_idx, addr_err);

		// Stop and stay quiet
		mark = err_cnt;
		@(posedge iCLK);
		i_enable <= 1'b0;
		wait_idle();
		base = aw_rise;
		repeat (20) @(negedge iCLK);
		if (aw_rise != base)
		begin
			err_cnt++;
			$display("ERROR at %0t ns: AWVALID rose after i_enable was lowered", $time);
		end
		if (done_cnt != b_cnt)
		begin
			err_cnt++;
			$display("ERROR at %0t ns: %0d o_wdone pulses for %0d B handshakes",
				$time, done_cnt, b_cnt);
		end
		check_idle(1'b0);                    // All OKAY so far
		$display("Test 4 completion pulses: %0d errors", err_cnt - mark);

		mark = err_cnt;
		check_avg("o_avg_cycles", o_avg_cycles, exp_avg());
		$display("Test 5 average: %0d errors", err_cnt - mark);

		// One SLVERR, then OKAY again
		mark = err_cnt;
		resp_sel = 2'b10;
		base     = b_cnt;
		@(posedge iCLK);
		i_enable <= 1'b1;
		wait (b_cnt >= base + 1);
		resp_sel = RESP_OKAY;
		wait (b_cnt >= base + 4);
		@(posedge iCLK);
		i_enable <= 1'b0;
		wait_idle();
		repeat (2) @(negedge iCLK);
		check_idle(1'b1);                    // Sticky after later OKAYs
		@(posedge iCLK);
		iRST <= 1'b1;
		repeat (4) @(posedge iCLK);
		iRST <= 1'b0;
		@(negedge iCLK);
		check_idle(1'b0);                    // Only reset clears it
		$display("Test 6 error flag: %0d errors", err_cnt - mark);

		$display("Summary: 6 tests, %0d checks, %0d errors", chk_cnt, err_cnt);
		if (err_cnt == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

	// Watchdog
	initial
	begin
		#(WATCHDOG_NS);
		$display("Watchdog expired at %0t ns with %0d bursts done", $time, b_cnt);
		$display("TESTS FAILED");
		$finish;
	end

endmodule

// ==== ddr_wr_traffic.f ====
axi_wr_pkg.sv
ddr_map_pkg.sv
wr_addr_gen.sv
wr_pattern_gen.sv
wr_burst_ctrl.sv
wr_speed_avg.sv
ddr_wr_traffic.sv
ddr_wr_traffic_asserts.sv
tb_ddr_wr_traffic.sv
